// File: design/alu_pkg.sv
package alu_pkg;

	// Data width of the unit
	localparam int default_xlen = 32;

	// Instruction number as seen by the execution element
	typedef logic [5:0] opcode_t;

	localparam opcode_t op_add = 6'd8;
	localparam opcode_t op_addi = 6'd9;
	localparam opcode_t op_sub = 6'd10;
	localparam opcode_t op_lui = 6'd11;

	// Iterative divide and single cycle multiply
	localparam opcode_t op_div = 6'd12;
	localparam opcode_t op_mult = 6'd13;
	localparam opcode_t op_divi = 6'd14;
	localparam opcode_t op_multi = 6'd15;

	// Barrel shifter
	localparam opcode_t op_sll = 6'd16;
	localparam opcode_t op_sra = 6'd17;
	localparam opcode_t op_srl = 6'd18;

	// Bitwise logic, 19 is unused
	localparam opcode_t op_and = 6'd20;
	localparam opcode_t op_andi = 6'd21;
	localparam opcode_t op_or = 6'd22;
	localparam opcode_t op_ori = 6'd23;
	localparam opcode_t op_xor = 6'd24;
	localparam opcode_t op_xori = 6'd25;
	localparam opcode_t op_nor = 6'd26;

endpackage

// File: design/divider.sv
`timescale 1ns/10ps

module alu_divider #(
	parameter int xlen = alu_pkg::default_xlen
) (
	input logic clk,
	input logic enabled,
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b,
	output logic [xlen-1:0] c,
	output logic completed
);

	localparam int cnt_w = $clog2(xlen + 1);

	logic loaded;
	logic [cnt_w-1:0] count;
	logic [xlen-1:0] rem;
	logic [xlen-1:0] quot;
	logic [xlen-1:0] dvs;
	logic neg;
	logic zero_div;
	logic [xlen:0] trial;
	logic [xlen:0] diff;

	// Partial remainder with next dividend bit shifted in
	always_comb begin
		trial = {rem, quot[xlen-1]};
		diff = trial - {1'b0, dvs};
	end

	always_ff @(posedge clk) begin
		if (!enabled) begin
			loaded <= 1'b0;
			completed <= 1'b0;
			count <= '0;
			neg <= 1'b0;
			zero_div <= 1'b0;
		end else if (!loaded) begin
			// First enabled edge takes the operands
			loaded <= 1'b1;
			count <= cnt_w'(xlen);
			rem <= '0;
			quot <= a[xlen-1] ? -a : a; // Dividend magnitude
			dvs <= b[xlen-1] ? -b : b; // Divisor magnitude
			neg <= a[xlen-1] ^ b[xlen-1];
			zero_div <= (b == '0);
		end else if (count != '0) begin
			if (!diff[xlen]) begin
				rem <= diff[xlen-1:0]; // Subtract fits
				quot <= {quot[xlen-2:0], 1'b1};
			end else begin
				rem <= trial[xlen-1:0];
				quot <= {quot[xlen-2:0], 1'b0};
			end
			count <= count - 1'b1;
			if (count == cnt_w'(1)) begin
				completed <= 1'b1; // Last quotient bit
			end
		end
	end

	// Sign fix, truncates toward zero
	always_comb begin
		if (zero_div) begin
			c = '1;
		end else if (neg) begin
			c = -quot;
		end else begin
			c = quot;
		end
	end

endmodule

// File: design/alu_exec_element.sv
`timescale 1ns/10ps

module alu_exec_element #(
	parameter int xlen = alu_pkg::default_xlen
) (
	input logic clk,
	input logic reset,
	output logic completed,
	input alu_pkg::opcode_t inst_num,
	input logic [xlen-1:0] const16_x,
	input logic [$clog2(xlen)-1:0] shift5,
	input logic [xlen-1:0] rs,
	input logic [xlen-1:0] rt,
	output logic [xlen-1:0] out
);

	localparam int sh_w = $clog2(xlen);
	localparam int half = xlen / 2;

	logic [xlen-1:0] shift [sh_w+1];
	logic [xlen-1:0] div_b;
	logic [xlen-1:0] div_c;
	logic div_enabled;
	logic div_completed;

	alu_divider #(
		.xlen(xlen)
	) u_divider (
		.clk(clk),
		.enabled(div_enabled),
		.a(rs),
		.b(div_b),
		.c(div_c),
		.completed(div_completed)
	);

	always_comb begin
		case (inst_num)
			alu_pkg::op_div: div_b = rt;
			alu_pkg::op_divi: div_b = const16_x;
			default: div_b = xlen'(1);
		endcase
	end

	assign shift[0] = rs;

	// One stage per shift amount bit
	for (genvar i = 0; i < sh_w; i++) begin : g_shift
		localparam int amt = 2 ** i;
		logic [xlen-1:0] moved;

		always_comb begin
			case (inst_num)
				alu_pkg::op_sll: moved = {shift[i][xlen-1-amt:0], {amt{1'b0}}};
				alu_pkg::op_sra: moved = {{amt{rs[xlen-1]}}, shift[i][xlen-1:amt]};
				alu_pkg::op_srl: moved = {{amt{1'b0}}, shift[i][xlen-1:amt]};
				default: moved = shift[i];
			endcase
		end

		assign shift[i+1] = shift5[i] ? moved : shift[i];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			completed <= 1'b0;
			div_enabled <= 1'b0;
		end else if (!completed) begin
			case (inst_num)
				alu_pkg::op_add: begin
					out <= rs + rt;
					completed <= 1'b1;
				end
				alu_pkg::op_addi: begin
					out <= rs + const16_x;
					completed <= 1'b1;
				end
				alu_pkg::op_sub: begin
					out <= rs - rt;
					completed <= 1'b1;
				end
				alu_pkg::op_lui: begin
					out <= {const16_x[half-1:0], {half{1'b0}}};
					completed <= 1'b1;
				end
				alu_pkg::op_div, alu_pkg::op_divi: begin
					if (!div_enabled) begin
						div_enabled <= 1'b1; // Start divider
					end else if (div_completed) begin
						out <= div_c;
						div_enabled <= 1'b0;
						completed <= 1'b1;
					end
				end
				alu_pkg::op_mult: begin
					out <= $signed(rs) * $signed(rt); // Low half only
					completed <= 1'b1;
				end
				alu_pkg::op_multi: begin
					out <= $signed(rs) * $signed(const16_x);
					completed <= 1'b1;
				end
				alu_pkg::op_sll, alu_pkg::op_sra, alu_pkg::op_srl: begin
					out <= shift[sh_w];
					completed <= 1'b1;
				end
				alu_pkg::op_and: begin
					out <= rs & rt;
					completed <= 1'b1;
				end
				alu_pkg::op_andi: begin
					out <= {{half{1'b0}}, rs[half-1:0] & const16_x[half-1:0]};
					completed <= 1'b1;
				end
				alu_pkg::op_or: begin
					out <= rs | rt;
					completed <= 1'b1;
				end
				alu_pkg::op_ori: begin
					out <= {rs[xlen-1:half], rs[half-1:0] | const16_x[half-1:0]};
					completed <= 1'b1;
				end
				alu_pkg::op_xor: begin
					out <= rs ^ rt;
					completed <= 1'b1;
				end
				alu_pkg::op_xori: begin
					out <= {rs[xlen-1:half], rs[half-1:0] ^ const16_x[half-1:0]};
					completed <= 1'b1;
				end
				alu_pkg::op_nor: begin
					out <= ~(rs | rt);
					completed <= 1'b1;
				end
				default: begin
					completed <= 1'b1; // out keeps last value
				end
			endcase
		end
	end

endmodule

// File: design/alu_exec_stage.sv
`timescale 1ns/10ps

module alu_exec_stage #(
	parameter int xlen = alu_pkg::default_xlen
) (
	input logic clk,
	input logic reset,
	input logic issue,
	input alu_pkg::opcode_t inst_num,
	input logic [xlen-1:0] rs,
	input logic [xlen-1:0] rt,
	input logic [xlen-1:0] const16_x,
	input logic [$clog2(xlen)-1:0] shift5,
	output logic busy,
	output logic done,
	output logic [xlen-1:0] result
);

	logic accept;
	logic el_reset;
	logic el_completed;
	logic [xlen-1:0] el_out;
	alu_pkg::opcode_t inst_q;
	logic [xlen-1:0] rs_q;
	logic [xlen-1:0] rt_q;
	logic [xlen-1:0] const_q;
	logic [$clog2(xlen)-1:0] shift_q;

	assign accept = issue && !busy; // Ignored while busy
	assign el_reset = reset || accept;

	// Operand copies stay put until done
	always_ff @(posedge clk) begin
		if (accept) begin
			inst_q <= inst_num;
			rs_q <= rs;
			rt_q <= rt;
			const_q <= const16_x;
			shift_q <= shift5;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			result <= '0;
		end else begin
			done <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
			end else if (busy && el_completed) begin
				busy <= 1'b0;
				done <= 1'b1;
				result <= el_out;
			end
		end
	end

	alu_exec_element #(
		.xlen(xlen)
	) u_element (
		.clk(clk),
		.reset(el_reset),
		.completed(el_completed),
		.inst_num(inst_q),
		.const16_x(const_q),
		.shift5(shift_q),
		.rs(rs_q),
		.rt(rt_q),
		.out(el_out)
	);

endmodule

// File: design/alu_top.sv
`timescale 1ns/10ps

module alu_top #(
	parameter int xlen = alu_pkg::default_xlen
) (
	input logic clk,
	input logic reset,
	input logic issue,
	input alu_pkg::opcode_t inst_num,
	input logic [xlen-1:0] rs,
	input logic [xlen-1:0] rt,
	input logic [xlen-1:0] const16_x,
	input logic [$clog2(xlen)-1:0] shift5,
	output logic busy,
	output logic done,
	output logic [xlen-1:0] result
);

	alu_exec_stage #(
		.xlen(xlen)
	) u_stage (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.inst_num(inst_num),
		.rs(rs),
		.rt(rt),
		.const16_x(const16_x),
		.shift5(shift5),
		.busy(busy),
		.done(done),
		.result(result)
	);

endmodule

// File: tests/alu_ref.svh
`ifndef alu_ref_svh
`define alu_ref_svh

// Expected value of one instruction on a 32-bit datapath
function automatic logic [31:0] alu_ref_result(
	input alu_pkg::opcode_t op,
	input logic [31:0] rs,
	input logic [31:0] rt,
	input logic [31:0] imm,
	input logic [4:0] sh,
	input logic [31:0] prev
);
	logic [63:0] product;
	logic [63:0] factor;
	longint dividend;
	longint divisor;
	longint quotient;
	logic [31:0] value;

	value = prev; // Undefined opcodes repeat
	case (op)
		alu_pkg::op_add: begin
			value = rs + rt;
		end
		alu_pkg::op_addi: begin
			value = rs + imm;
		end
		alu_pkg::op_sub: begin
			value = rs - rt;
		end
		alu_pkg::op_lui: begin
			value = {imm[15:0], 16'h0000};
		end
		alu_pkg::op_div, alu_pkg::op_divi: begin
			dividend = {{32{rs[31]}}, rs};
			if (op == alu_pkg::op_div) begin
				divisor = {{32{rt[31]}}, rt};
			end else begin
				divisor = {{32{imm[31]}}, imm};
			end
			if (divisor == 0) begin
				value = '1;
			end else begin
				// 64-bit math keeps the most negative quotient exact
				quotient = dividend / divisor;
				value = quotient[31:0];
			end
		end
		alu_pkg::op_mult, alu_pkg::op_multi: begin
			if (op == alu_pkg::op_mult) begin
				factor = {{32{rt[31]}}, rt};
			end else begin
				factor = {{32{imm[31]}}, imm};
			end
			product = {{32{rs[31]}}, rs} * factor;
			value = product[31:0]; // Low half
		end
		alu_pkg::op_sll: value = rs << sh;
		alu_pkg::op_sra: value = $signed(rs) >>> sh;
		alu_pkg::op_srl: value = rs >> sh;
		alu_pkg::op_and: value = rs & rt;
		alu_pkg::op_andi: value = {16'h0000, rs[15:0] & imm[15:0]};
		alu_pkg::op_or: value = rs | rt;
		alu_pkg::op_ori: value = {rs[31:16], rs[15:0] | imm[15:0]};
		alu_pkg::op_xor: value = rs ^ rt;
		alu_pkg::op_xori: value = {rs[31:16], rs[15:0] ^ imm[15:0]};
		alu_pkg::op_nor: value = ~(rs | rt);
		default: begin
			value = prev;
		end
	endcase
	return value;
endfunction

`endif

// File: tests/alu_tb.sv
`timescale 1ns/10ps

module alu_tb;

	localparam int xlen = alu_pkg::default_xlen;
	localparam int sh_w = $clog2(xlen);
	localparam int max_cycles = 300 * (alu_pkg::default_xlen + 8) + 100;

	// Defined opcodes first, then a few holes in the map
	localparam alu_pkg::opcode_t op_table [22] = '{
		alu_pkg::op_add, alu_pkg::op_addi, alu_pkg::op_sub, alu_pkg::op_lui,
		alu_pkg::op_div, alu_pkg::op_mult, alu_pkg::op_divi, alu_pkg::op_multi,
		alu_pkg::op_sll, alu_pkg::op_sra, alu_pkg::op_srl, alu_pkg::op_and,
		alu_pkg::op_andi, alu_pkg::op_or, alu_pkg::op_ori, alu_pkg::op_xor,
		alu_pkg::op_xori, alu_pkg::op_nor, 6'd0, 6'd7, 6'd19, 6'd63
	};
	localparam logic [4:0] shift_amts [3] = '{5'd0, 5'd1, 5'd31};

	logic clk;
	logic reset;
	logic issue;
	alu_pkg::opcode_t inst_num;
	logic [xlen-1:0] rs;
	logic [xlen-1:0] rt;
	logic [xlen-1:0] const16_x;
	logic [sh_w-1:0] shift5;
	logic busy;
	logic done;
	logic [xlen-1:0] result;

	int cycles;
	int issued;
	int finished;
	logic [xlen-1:0] model_prev; // Expected result of the last instruction
	logic [xlen-1:0] exp_q [$];
	int cyc_q [$];
	bit timed_q [$];

	`include "alu_ref.svh"

	alu_top u_dut (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.inst_num(inst_num),
		.rs(rs),
		.rt(rt),
		.const16_x(const16_x),
		.shift5(shift5),
		.busy(busy),
		.done(done),
		.result(result)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			$display("*** TEST FAILED ***");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(
		input logic [xlen-1:0] actual,
		input logic [xlen-1:0] expected,
		input string what
	);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	// Results are sampled mid-cycle, away from the clock edge
	always @(negedge clk) begin : compare
		logic [xlen-1:0] want;
		int start;
		bit fixed;

		if (!reset && done) begin
			if (exp_q.size() == 0) begin
				$display("done was pulsed at %0t ns with no instruction outstanding", $time);
				$display("*** TEST FAILED ***");
				$fatal(1, "unexpected done");
			end else begin
				want = exp_q.pop_front();
				start = cyc_q.pop_front();
				fixed = timed_q.pop_front();
				finished++;
				check_value(result, want, "result");
				if (fixed) begin
					check_value(cycles - start, 2, "done latency in cycles");
				end
			end
		end
	end

	function automatic logic [xlen-1:0] sign_extend(input logic [15:0] v);
		return {{(xlen-16){v[15]}}, v};
	endfunction

	task automatic drive_inputs(
		input alu_pkg::opcode_t op,
		input logic [xlen-1:0] a,
		input logic [xlen-1:0] b,
		input logic [xlen-1:0] imm,
		input logic [sh_w-1:0] amt
	);
		inst_num = op;
		rs = a;
		rt = b;
		const16_x = imm;
		shift5 = amt;
		issue = 1'b1;
		@(posedge clk);
		#1;
		issue = 1'b0;
	endtask

	task automatic start_op(
		input alu_pkg::opcode_t op,
		input logic [xlen-1:0] a,
		input logic [xlen-1:0] b,
		input logic [xlen-1:0] imm,
		input logic [sh_w-1:0] amt
	);
		logic [xlen-1:0] want;

		want = alu_ref_result(op, a, b, imm, amt, model_prev);
		model_prev = want;
		drive_inputs(op, a, b, imm, amt);
		exp_q.push_back(want);
		cyc_q.push_back(cycles); // Edge that sampled issue
		timed_q.push_back(op != alu_pkg::op_div && op != alu_pkg::op_divi);
		issued++;
	endtask

	task automatic wait_idle();
		while (busy) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_op(
		input alu_pkg::opcode_t op,
		input logic [xlen-1:0] a,
		input logic [xlen-1:0] b,
		input logic [xlen-1:0] imm,
		input logic [sh_w-1:0] amt
	);
		start_op(op, a, b, imm, amt);
		wait_idle();
	endtask

	task automatic random_op();
		int unsigned pick;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] r;

		pick = $urandom % 22;
		a = $urandom;
		b = $urandom;
		r = $urandom;
		if ($urandom % 8 == 0) begin
			b = '0; // Zero divisors now and then
			r[15:0] = '0;
		end
		run_op(op_table[pick], a, b, sign_extend(r[15:0]), r[20:16]);
	endtask

	initial begin : stimulus
		clk = 1'b0;
		reset = 1'b1;
		issue = 1'b0;
		inst_num = '0;
		rs = '0;
		rt = '0;
		const16_x = '0;
		shift5 = '0;
		cycles = 0;
		issued = 0;
		finished = 0;
		model_prev = '0;
		void'($urandom(32'hec80_fc60));

		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		check_value(xlen'(busy), '0, "busy after reset");
		check_value(xlen'(done), '0, "done after reset");
		check_value(result, '0, "result after reset");

		// Arithmetic and LUI
		run_op(alu_pkg::op_add, 32'd5, 32'd7, '0, '0);
		run_op(alu_pkg::op_add, 32'hffff_ffff, 32'd1, '0, '0);
		run_op(alu_pkg::op_addi, 32'd100, '0, sign_extend(16'hff9c), '0);
		run_op(alu_pkg::op_sub, 32'd3, 32'd10, '0, '0);
		run_op(alu_pkg::op_lui, '0, '0, sign_extend(16'h1234), '0);
		run_op(alu_pkg::op_lui, 32'hdead_beef, '0, sign_extend(16'h8000), '0);

		// Logic, immediates touch the low half only
		run_op(alu_pkg::op_and, 32'hdead_beef, 32'h0ff0_f0f0, '0, '0);
		run_op(alu_pkg::op_andi, 32'hdead_beef, '0, sign_extend(16'hff0f), '0);
		run_op(alu_pkg::op_or, 32'h1200_0034, 32'h0056_7800, '0, '0);
		run_op(alu_pkg::op_ori, 32'hdead_0000, '0, sign_extend(16'h8421), '0);
		run_op(alu_pkg::op_xor, 32'haaaa_5555, 32'hffff_0000, '0, '0);
		run_op(alu_pkg::op_xori, 32'h1234_5678, '0, sign_extend(16'hffff), '0);
		run_op(alu_pkg::op_nor, 32'hf0f0_0000, 32'h0000_0f0f, '0, '0);

		// Shifts, fixed and random amounts
		foreach (shift_amts[k]) begin
			run_op(alu_pkg::op_sll, 32'h8000_0003, '0, '0, shift_amts[k]);
			run_op(alu_pkg::op_sra, 32'h8000_0003, '0, '0, shift_amts[k]);
			run_op(alu_pkg::op_srl, 32'h8000_0003, '0, '0, shift_amts[k]);
		end
		repeat (4) begin
			run_op(alu_pkg::op_sll, $urandom, '0, '0, sh_w'($urandom));
			run_op(alu_pkg::op_sra, $urandom | 32'h8000_0000, '0, '0, sh_w'($urandom));
			run_op(alu_pkg::op_srl, $urandom, '0, '0, sh_w'($urandom));
		end

		// Multiply and divide
		run_op(alu_pkg::op_mult, 32'd7, 32'hffff_fffd, '0, '0);
		run_op(alu_pkg::op_mult, 32'h1234_5678, 32'h9abc_def0, '0, '0);
		run_op(alu_pkg::op_multi, 32'hffff_fffb, '0, sign_extend(16'hfff0), '0);
		run_op(alu_pkg::op_div, 32'd100, 32'd7, '0, '0);
		run_op(alu_pkg::op_div, -32'sd100, 32'd7, '0, '0);
		run_op(alu_pkg::op_div, 32'd100, -32'sd7, '0, '0);
		run_op(alu_pkg::op_div, -32'sd100, -32'sd7, '0, '0);
		run_op(alu_pkg::op_div, 32'h8000_0000, 32'hffff_ffff, '0, '0);
		run_op(alu_pkg::op_div, 32'd5, 32'd0, '0, '0);
		run_op(alu_pkg::op_divi, -32'sd1000, '0, sign_extend(16'd7), '0);
		run_op(alu_pkg::op_divi, -32'sd1000, '0, sign_extend(16'hfff9), '0);
		run_op(alu_pkg::op_divi, 32'd1234, '0, '0, '0);

		// Issue while busy is dropped, then undefined opcodes
		start_op(alu_pkg::op_add, 32'd40, 32'd2, '0, '0);
		drive_inputs(alu_pkg::op_sub, 32'd1, 32'd9, '0, '0);
		wait_idle();
		run_op(6'd19, 32'h5555_5555, 32'h1111_1111, '0, '0);
		run_op(6'd63, 32'h0, 32'h0, '0, '0);

		repeat (300) begin
			random_op();
		end

		repeat (4) @(posedge clk);
		#1;
		check_value(xlen'(finished), xlen'(issued), "number of done pulses");

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+tests
design/alu_pkg.sv
design/divider.sv
design/alu_exec_element.sv
design/alu_exec_stage.sv
design/alu_top.sv
tests/alu_tb.sv

// File: Makefile
TOP = alu_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary -j 0 --top-module $(TOP) -f vlog.f -Mdir obj_dir -o alu_sim
	./obj_dir/alu_sim | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
